/* periph_defs.svh */
/*
 * Peripheral bus definitions: widths, memory window, register addresses,
 * LFSR polynomial and seed, stopwatch prescale
 */
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// bus widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// data memory window, byte base and size in words
`define DMEM_BASE 32'h1001_0000
`define DMEM_WORDS 256

// memory-mapped peripheral registers, word aligned
`define STOPWATCH_ADDR 32'hFF20_0510
`define LFSR_ADDR 32'hFF20_0514
`define BREAK_ADDR 32'hFF20_0520

// galois feedback mask, right-shifting form
`define LFSR_TAPS 32'h8020_0003
// reset seed, also replaces a zero seed
`define LFSR_SEED 32'h1234_5678

// clock cycles per stopwatch tick at 50 MHz
`define TICK_CYCLES 50000

// seven-segment digits on the board
`define HEX_DIGITS 6

`endif

/* periph_pkg.sv */
/*
 * Peripheral types shared by the bus peripherals and the display path
 */
`default_nettype none

`include "periph_defs.svh"

package periph_pkg;

    // one bus data word
    typedef logic [`DATA_WIDTH-1:0] dataT;
    // byte address on the data bus
    typedef logic [`ADDR_WIDTH-1:0] addrT;
    // one enable per byte lane
    typedef logic [`DATA_WIDTH/8-1:0] byteEnT;
    // active-low segments, bit 0 is a, bit 6 is g
    typedef logic [6:0] segT;

    // display source, codes match the board switch pair
    typedef enum logic [1:0] {
        dispNone  = 2'd0,
        dispDebug = 2'd1,
        dispInstr = 2'd2,
        dispPc    = 2'd3
    } dispSelT;

endpackage

`default_nettype wire

/* dataMemory.sv */
/*
 * Data memory: word-organized RAM on the data bus,
 * byte-lane writes, combinational reads
 */
`default_nettype none

`include "periph_defs.svh"

module dataMemory
    import periph_pkg::*;
(
    input  wire logic   iCLK,
    input  wire logic   dReadEnable,
    input  wire logic   dWriteEnable,
    input  wire byteEnT dByteEnable,
    input  wire addrT   dAddress,
    input  wire dataT   dWriteData,
    output dataT        readData,
    output logic        hit
);

    // word index width and window size in bytes
    localparam int wordBits = $clog2(`DMEM_WORDS);
    localparam int byteLanes = `DATA_WIDTH / 8;
    localparam addrT windowBytes = addrT'(`DMEM_WORDS * byteLanes);

    // storage, contents undefined after reset
    dataT mem [`DMEM_WORDS];

    addrT offset;
    logic inWindow;
    logic [wordBits-1:0] wordIndex;

    // offset from the window base
    assign offset = dAddress - `DMEM_BASE;

    // below the base the subtraction wraps high, so one compare covers both ends
    assign inWindow = (offset < windowBytes);

    // drop the byte offset bits
    assign wordIndex = offset[wordBits+1:2];

    // read hit only while the master reads this window
    assign hit = dReadEnable && inWindow;

    // combinational read of the addressed word
    assign readData = mem[wordIndex];

    // write only the enabled byte lanes
    always_ff @(posedge iCLK) begin
        if (dWriteEnable && inWindow) begin
            for (int lane = 0; lane < byteLanes; lane++) begin
                if (dByteEnable[lane]) begin
                    mem[wordIndex][8*lane +: 8] <= dWriteData[8*lane +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* stopwatch.sv */
/*
 * Stopwatch: prescaled tick counter, read over the bus,
 * any write clears the count and the prescaler
 */
`default_nettype none

`include "periph_defs.svh"

module stopwatch
    import periph_pkg::*;
#(
    parameter int tickCycles = `TICK_CYCLES
) (
    input  wire logic iCLK,
    input  wire logic reset,
    input  wire logic dReadEnable,
    input  wire logic dWriteEnable,
    input  wire addrT dAddress,
    output dataT      readData,
    output logic      hit
);

    // at least one bit even for a prescale of 1
    localparam int preWidth = (tickCycles > 1) ? $clog2(tickCycles) : 1;
    localparam logic [preWidth-1:0] preLast = preWidth'(tickCycles - 1);

    logic [preWidth-1:0] prescale;
    dataT tickCount;
    logic addrMatch;

    assign addrMatch = (dAddress == `STOPWATCH_ADDR);
    assign hit = dReadEnable && addrMatch;
    assign readData = tickCount;

    // prescaler wraps at tickCycles, each wrap is one tick
    always_ff @(posedge iCLK) begin
        if (reset || (dWriteEnable && addrMatch)) begin
            prescale <= '0;
            tickCount <= '0;
        end else if (prescale == preLast) begin
            prescale <= '0;
            tickCount <= tickCount + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* lfsrGenerator.sv */
/*
 * Random source: 32-bit Galois LFSR stepping every clock,
 * reseeded by a bus write
 */
`default_nettype none

`include "periph_defs.svh"

module lfsrGenerator
    import periph_pkg::*;
(
    input  wire logic iCLK,
    input  wire logic reset,
    input  wire logic dReadEnable,
    input  wire logic dWriteEnable,
    input  wire addrT dAddress,
    input  wire dataT dWriteData,
    output dataT      readData,
    output logic      hit
);

    dataT lfsrState;
    dataT nextState;
    logic addrMatch;

    assign addrMatch = (dAddress == `LFSR_ADDR);
    assign hit = dReadEnable && addrMatch;
    assign readData = lfsrState;

    // shift right, fold the taps in when a one falls out
    assign nextState = lfsrState[0] ? ((lfsrState >> 1) ^ `LFSR_TAPS) : (lfsrState >> 1);

    always_ff @(posedge iCLK) begin
        if (reset) begin
            lfsrState <= `LFSR_SEED;
        end else if (dWriteEnable && addrMatch) begin
            // all-zero state never leaves zero
            lfsrState <= (dWriteData == '0) ? `LFSR_SEED : dWriteData;
        end else begin
            lfsrState <= nextState;
        end
    end

endmodule

`default_nettype wire

/* breakpointUnit.sv */
/*
 * Breakpoint: holds a program-counter address from the bus,
 * sets a sticky break flag on a match
 */
`default_nettype none

`include "periph_defs.svh"

module breakpointUnit
    import periph_pkg::*;
(
    input  wire logic iCLK,
    input  wire logic reset,
    input  wire logic dReadEnable,
    input  wire logic dWriteEnable,
    input  wire addrT dAddress,
    input  wire dataT dWriteData,
    input  wire dataT pc,
    output dataT      readData,
    output logic      hit,
    output logic      breakHit
);

    dataT breakAddr;
    logic addrMatch;
    logic pcMatch;

    assign addrMatch = (dAddress == `BREAK_ADDR);
    assign hit = dReadEnable && addrMatch;
    assign readData = breakAddr;

    // address zero means disarmed
    assign pcMatch = (breakAddr != '0) && (pc == breakAddr);

    always_ff @(posedge iCLK) begin
        if (reset) begin
            breakAddr <= '0;
            breakHit <= 1'b0;
        end else if (dWriteEnable && addrMatch) begin
            // new address rearms the flag
            breakAddr <= dWriteData;
            breakHit <= 1'b0;
        end else if (pcMatch) begin
            breakHit <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hexDisplay.sv */
/*
 * Seven-segment monitor: picks pc, instruction or debug word
 * and shows its low nibbles as active-low hex digits
 */
`default_nettype none

`include "periph_defs.svh"

module hexDisplay
    import periph_pkg::*;
(
    input  wire dispSelT dispSel,
    input  wire dataT    pc,
    input  wire dataT    instr,
    input  wire dataT    debug,
    output segT          hex0,
    output segT          hex1,
    output segT          hex2,
    output segT          hex3,
    output segT          hex4,
    output segT          hex5
);

    // hex font, segments gfedcba, low lights the segment
    function automatic segT hexFont(input logic [3:0] nibble);
        case (nibble)
            4'h0: hexFont = 7'b1000000;
            4'h1: hexFont = 7'b1111001;
            4'h2: hexFont = 7'b0100100;
            4'h3: hexFont = 7'b0110000;
            4'h4: hexFont = 7'b0011001;
            4'h5: hexFont = 7'b0010010;
            4'h6: hexFont = 7'b0000010;
            4'h7: hexFont = 7'b1111000;
            4'h8: hexFont = 7'b0000000;
            4'h9: hexFont = 7'b0010000;
            4'hA: hexFont = 7'b0001000;
            4'hB: hexFont = 7'b0000011;
            4'hC: hexFont = 7'b1000110;
            4'hD: hexFont = 7'b0100001;
            4'hE: hexFont = 7'b0000110;
            default: hexFont = 7'b0001110;
        endcase
    endfunction

    dataT shown;
    segT digits [`HEX_DIGITS];

    // monitor source, free slot shows zeros
    always_comb begin
        case (dispSel)
            dispPc: shown = pc;
            dispInstr: shown = instr;
            dispDebug: shown = debug;
            default: shown = '0;
        endcase
    end

    // digit k from nibble k
    for (genvar k = 0; k < `HEX_DIGITS; k++) begin : gDigit
        assign digits[k] = hexFont(shown[4*k +: 4]);
    end

    assign hex0 = digits[0];
    assign hex1 = digits[1];
    assign hex2 = digits[2];
    assign hex3 = digits[3];
    assign hex4 = digits[4];
    assign hex5 = digits[5];

endmodule

`default_nettype wire

/* topDE.sv */
/*
 * Board top, peripheral side: data memory, stopwatch, LFSR and
 * breakpoint on one data bus, plus the hex monitor display
 */
`default_nettype none

`include "periph_defs.svh"

module topDE
    import periph_pkg::*;
#(
    parameter int tickCycles = `TICK_CYCLES
) (
    input  wire logic    iCLK,
    input  wire logic    reset,
    input  wire logic    dReadEnable,
    input  wire logic    dWriteEnable,
    input  wire byteEnT  dByteEnable,
    input  wire addrT    dAddress,
    input  wire dataT    dWriteData,
    input  wire dataT    pc,
    input  wire dataT    instr,
    input  wire dataT    debug,
    input  wire dispSelT dispSel,
    output dataT         dReadData,
    output logic         breakHit,
    output segT          hex0,
    output segT          hex1,
    output segT          hex2,
    output segT          hex3,
    output segT          hex4,
    output segT          hex5
);

    // per-peripheral read data and hit
    dataT memData, swData, lfsrData, breakData;
    logic memHit, swHit, lfsrHit, breakRegHit;

    dataMemory memData0 (
        .iCLK(iCLK),
        .dReadEnable(dReadEnable),
        .dWriteEnable(dWriteEnable),
        .dByteEnable(dByteEnable),
        .dAddress(dAddress),
        .dWriteData(dWriteData),
        .readData(memData),
        .hit(memHit)
    );

    stopwatch #(.tickCycles(tickCycles)) stopwatch0 (
        .iCLK(iCLK),
        .reset(reset),
        .dReadEnable(dReadEnable),
        .dWriteEnable(dWriteEnable),
        .dAddress(dAddress),
        .readData(swData),
        .hit(swHit)
    );

    lfsrGenerator lfsr0 (
        .iCLK(iCLK),
        .reset(reset),
        .dReadEnable(dReadEnable),
        .dWriteEnable(dWriteEnable),
        .dAddress(dAddress),
        .dWriteData(dWriteData),
        .readData(lfsrData),
        .hit(lfsrHit)
    );

    // compares against the outside program counter
    breakpointUnit break0 (
        .iCLK(iCLK),
        .reset(reset),
        .dReadEnable(dReadEnable),
        .dWriteEnable(dWriteEnable),
        .dAddress(dAddress),
        .dWriteData(dWriteData),
        .pc(pc),
        .readData(breakData),
        .hit(breakRegHit),
        .breakHit(breakHit)
    );

    hexDisplay display0 (
        .dispSel(dispSel),
        .pc(pc),
        .instr(instr),
        .debug(debug),
        .hex0(hex0),
        .hex1(hex1),
        .hex2(hex2),
        .hex3(hex3),
        .hex4(hex4),
        .hex5(hex5)
    );

    // read merge, address windows never overlap
    // unmapped or idle bus reads as zero
    always_comb begin
        dReadData = '0;
        if (dReadEnable) begin
            if (memHit) begin
                dReadData = memData;
            end else if (swHit) begin
                dReadData = swData;
            end else if (lfsrHit) begin
                dReadData = lfsrData;
            end else if (breakRegHit) begin
                dReadData = breakData;
            end
        end
    end

endmodule

`default_nettype wire

/* topDeTbTasks.svh */
/*
 * Testbench tasks for bus access, typed compares, reference models and tests
 */
`ifndef TOP_DE_TB_TASKS_SVH
`define TOP_DE_TB_TASKS_SVH

// every task starts and ends one unit after a rising edge
task automatic idle(input int cycles);
    repeat (cycles) begin
        @(posedge iCLK);
        #1;
    end
endtask

// write lands at the next edge
task automatic busWrite(input addrT addr, input dataT data, input byteEnT lanes);
    dWriteEnable = 1'b1;
    dAddress = addr;
    dWriteData = data;
    dByteEnable = lanes;
    idle(1);
    dWriteEnable = 1'b0;
    dByteEnable = '0;
endtask

// combinational read sampled just before the edge
task automatic busRead(input addrT addr, output dataT data);
    dReadEnable = 1'b1;
    dAddress = addr;
    #8;
    data = dReadData;
    idle(1);
    dReadEnable = 1'b0;
endtask

task automatic checkData(input string what, input dataT expected, input dataT actual);
    if (actual !== expected) begin
        $display("mismatch in %s, %s: expected %h, actual %h", testName, what, expected, actual);
        errorCount++;
    end
endtask

task automatic checkSeg(input string what, input segT expected, input segT actual);
    if (actual !== expected) begin
        $display("mismatch in %s, %s: expected %b, actual %b", testName, what, expected, actual);
        errorCount++;
    end
endtask

task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("mismatch in %s, %s: expected %b, actual %b", testName, what, expected, actual);
        errorCount++;
    end
endtask

// one line per finished test
task automatic finishTest();
    if (errorCount == testErrors) begin
        testsPassed++;
        $display("test %s: ok", testName);
    end else begin
        testsFailed++;
        $display("test %s: %0d errors", testName, errorCount - testErrors);
    end
    testErrors = errorCount;
endtask

// right shift with the taps folded in when a one drops out
function automatic dataT galoisStep(input dataT state);
    dataT next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ `LFSR_TAPS;
    end
    return next;
endfunction

// active-low gfedcba patterns
function automatic segT fontModel(input logic [3:0] nibble);
    case (nibble)
        4'h0: return 7'h40;
        4'h1: return 7'h79;
        4'h2: return 7'h24;
        4'h3: return 7'h30;
        4'h4: return 7'h19;
        4'h5: return 7'h12;
        4'h6: return 7'h02;
        4'h7: return 7'h78;
        4'h8: return 7'h00;
        4'h9: return 7'h10;
        4'hA: return 7'h08;
        4'hB: return 7'h03;
        4'hC: return 7'h46;
        4'hD: return 7'h21;
        4'hE: return 7'h06;
        default: return 7'h0E;
    endcase
endfunction

task automatic lfsrTest();
    dataT seedValue;
    dataT expected;
    dataT got;
    int m;
    int step;
    testName = "lfsr sequence";
    busRead(`LFSR_ADDR, got);
    checkData("reset seed", `LFSR_SEED, got);
    seedValue = $random(seed);
    if (seedValue == '0) begin
        seedValue = 32'h1;
    end
    // read m edges after the loading edge
    for (m = 1; m <= 6; m++) begin
        busWrite(`LFSR_ADDR, seedValue, 4'hF);
        idle(m);
        busRead(`LFSR_ADDR, got);
        expected = seedValue;
        for (step = 0; step < m; step++) begin
            expected = galoisStep(expected);
        end
        checkData("stepped state", expected, got);
    end
    busWrite(`LFSR_ADDR, '0, 4'hF);
    busRead(`LFSR_ADDR, got);
    checkData("zero seed", `LFSR_SEED, got);
    finishTest();
endtask

task automatic memoryTest();
    dataT model [`DMEM_WORDS];
    int index [8];
    dataT data;
    dataT got;
    byteEnT lanes;
    int i;
    int lane;
    testName = "memory byte lanes";
    for (i = 0; i < 8; i++) begin
        index[i] = (i * 37 + 5) % `DMEM_WORDS;
        model[index[i]] = $random(seed);
        busWrite(`DMEM_BASE + addrT'(index[i] * 4), model[index[i]], 4'hF);
    end
    // single bytes then halfwords
    for (i = 0; i < 12; i++) begin
        case (i % 6)
            0: lanes = 4'b0001;
            1: lanes = 4'b0010;
            2: lanes = 4'b0100;
            3: lanes = 4'b1000;
            4: lanes = 4'b0011;
            default: lanes = 4'b1100;
        endcase
        data = $random(seed);
        busWrite(`DMEM_BASE + addrT'(index[i % 8] * 4), data, lanes);
        for (lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                model[index[i % 8]][8*lane +: 8] = data[8*lane +: 8];
            end
        end
    end
    for (i = 0; i < 8; i++) begin
        busRead(`DMEM_BASE + addrT'(index[i] * 4), got);
        checkData("merged word", model[index[i]], got);
    end
    finishTest();
endtask

task automatic stopwatchTest();
    int idleList [6] = '{0, 3, 4, 7, 13, 21};
    dataT got;
    int i;
    testName = "stopwatch";
    for (i = 0; i < 6; i++) begin
        busWrite(`STOPWATCH_ADDR, $random(seed), 4'hF);
        idle(idleList[i]);
        busRead(`STOPWATCH_ADDR, got);
        // one tick per four edges since the clear
        checkData("tick count", dataT'(idleList[i] / 4), got);
    end
    finishTest();
endtask

task automatic breakpointTest();
    dataT breakAddr;
    dataT got;
    int cycles;
    int i;
    testName = "breakpoint";
    checkBit("flag after reset", 1'b0, breakHit);
    breakAddr = ($random(seed) & 32'hFFFF_FFFC) | 32'h0040_0000;
    busWrite(`BREAK_ADDR, breakAddr, 4'hF);
    // each non-matching pc is seen by one edge before the flag is sampled
    for (i = 0; i < 5; i++) begin
        pc = breakAddr ^ (32'h4 << i);
        idle(1);
        #8;
        checkBit("flag without match", 1'b0, breakHit);
        idle(1);
    end
    pc = breakAddr;
    cycles = 0;
    while (!breakHit && cycles < 20) begin
        idle(1);
        cycles++;
    end
    if (!breakHit) begin
        $display("%s: breakHit never rose", testName);
        errorCount++;
    end
    // sticky after pc moves on
    pc = breakAddr + 32'h4;
    idle(3);
    #8;
    checkBit("flag held", 1'b1, breakHit);
    idle(1);
    busRead(`BREAK_ADDR, got);
    checkData("address read", breakAddr, got);
    busWrite(`BREAK_ADDR, breakAddr + 32'h100, 4'hF);
    #8;
    checkBit("flag after rewrite", 1'b0, breakHit);
    idle(1);
    finishTest();
endtask

task automatic displayTest();
    dataT shownWord;
    dataT got;
    segT seen [`HEX_DIGITS];
    int sel;
    int k;
    testName = "display and read merge";
    for (sel = 0; sel < 4; sel++) begin
        dispSel = dispSelT'(sel);
        pc = $random(seed);
        instr = $random(seed);
        debug = $random(seed);
        // codes 1, 2, 3 pick debug, instr, pc
        case (sel)
            1: shownWord = debug;
            2: shownWord = instr;
            3: shownWord = pc;
            default: shownWord = '0;
        endcase
        #8;
        seen[0] = hex0;
        seen[1] = hex1;
        seen[2] = hex2;
        seen[3] = hex3;
        seen[4] = hex4;
        seen[5] = hex5;
        for (k = 0; k < `HEX_DIGITS; k++) begin
            checkSeg($sformatf("sel %0d digit %0d", sel, k), fontModel(shownWord[4*k +: 4]),
                     seen[k]);
        end
        idle(1);
    end
    // nothing decodes this address
    busRead(32'hFF20_0600, got);
    checkData("unmapped read", '0, got);
    finishTest();
endtask

`endif

/* topDeTb.sv */
/*
 * Testbench for the peripheral-side board top: directed bus tests
 * on memory, LFSR, stopwatch, breakpoint and the hex display
 */
`default_nettype none

`include "periph_defs.svh"

module topDeTb
    import periph_pkg::*;
();

    logic    iCLK;
    logic    reset;
    logic    dReadEnable;
    logic    dWriteEnable;
    byteEnT  dByteEnable;
    addrT    dAddress;
    dataT    dWriteData;
    dataT    pc;
    dataT    instr;
    dataT    debug;
    dispSelT dispSel;
    dataT    dReadData;
    logic    breakHit;
    segT     hex0;
    segT     hex1;
    segT     hex2;
    segT     hex3;
    segT     hex4;
    segT     hex5;

    // bookkeeping shared by the tests
    integer seed;
    int     errorCount;
    int     testErrors;
    int     testsPassed;
    int     testsFailed;
    string  testName;

    // four-cycle ticks keep the stopwatch test short
    topDE #(.tickCycles(4)) topDE_inst (
        .iCLK(iCLK),
        .reset(reset),
        .dReadEnable(dReadEnable),
        .dWriteEnable(dWriteEnable),
        .dByteEnable(dByteEnable),
        .dAddress(dAddress),
        .dWriteData(dWriteData),
        .pc(pc),
        .instr(instr),
        .debug(debug),
        .dispSel(dispSel),
        .dReadData(dReadData),
        .breakHit(breakHit),
        .hex0(hex0),
        .hex1(hex1),
        .hex2(hex2),
        .hex3(hex3),
        .hex4(hex4),
        .hex5(hex5)
    );

    // 10-unit clock
    initial begin
        iCLK = 1'b0;
        forever #5 iCLK = ~iCLK;
    end

    `include "topDeTbTasks.svh"

    initial begin
        seed = 32'hc6b99f4e;
        errorCount = 0;
        testErrors = 0;
        testsPassed = 0;
        testsFailed = 0;
        testName = "reset";
        reset = 1'b1;
        dReadEnable = 1'b0;
        dWriteEnable = 1'b0;
        dByteEnable = '0;
        dAddress = '0;
        dWriteData = '0;
        pc = '0;
        instr = '0;
        debug = '0;
        dispSel = dispNone;
        // three reset edges, then drive just after the edge
        repeat (3) @(posedge iCLK);
        #1;
        reset = 1'b0;
        // first read after reset must see the LFSR seed
        lfsrTest();
        memoryTest();
        stopwatchTest();
        breakpointTest();
        displayTest();
        $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
periph_pkg.sv
dataMemory.sv
stopwatch.sv
lfsrGenerator.sv
breakpointUnit.sv
hexDisplay.sv
topDE.sv
topDeTb.sv

/* Bender.yml */
package:
  name: topde_periph

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - dataMemory.sv
      - stopwatch.sv
      - lfsrGenerator.sv
      - breakpointUnit.sv
      - hexDisplay.sv
      - topDE.sv
  - target: test
    include_dirs:
      - .
    files:
      - topDeTb.sv
